// File: Bender.yml
package:
  name: kiwi_io

sources:
  - files:
      - design/kiwi_io_pkg.sv
      - design/cpu_bus_if.sv
      - design/ctrl_regs.sv
      - design/cycle_counters.sv
      - design/event_latches.sv
      - design/par_mux.sv
      - design/kiwi_io_top.sv
  - target: simulation
    files:
      - verif/kiwi_io_sva.sv
      - verif/kiwi_io_tb.sv

// File: compile.f
design/kiwi_io_pkg.sv
design/cpu_bus_if.sv
design/ctrl_regs.sv
design/cycle_counters.sv
design/event_latches.sv
design/par_mux.sv
design/kiwi_io_top.sv
verif/kiwi_io_sva.sv
verif/kiwi_io_tb.sv

// File: design/cpu_bus_if.sv
`timescale 1ns/10ps

interface cpu_bus_if
    import kiwi_io_pkg::*;
    ();

    // decoded opcode, one hot
    op_t   op;
    // top of stack, write data
    word_t tos;
    // single-cycle strobes
    logic  rd_reg;
    logic  wr_reg;
    logic  wr_evt;

    // cpu side drives everything
    modport src
    (
        output op,
        output tos,
        output rd_reg,
        output wr_reg,
        output wr_evt
    );

    // io blocks only listen
    modport snk
    (
        input  op,
        input  tos,
        input  rd_reg,
        input  wr_reg,
        input  wr_evt
    );

endinterface

// File: design/ctrl_regs.sv
`timescale 1ns/10ps

module ctrl_regs
    import kiwi_io_pkg::*;
(
    cpu_bus_if.snk bus,
    input  logic   cpu_clk,
    input  logic   rx_orst,
    output ctrl_t  ctrl,
    // adc
    output logic   adc_clken,
    output logic   adc_stenl,
    // attenuator dac
    output logic   da_dale,
    output logic   da_daclk,
    output logic   da_dadat,
    // gps front end
    output logic   gps_gscs,
    output logic   gps_gsclk,
    output logic   gps_gsdat,
    // device id port
    output logic   dna_read,
    output logic   dna_clk,
    output logic   dna_shift,
    // misc flags
    output logic   ewp,
    output logic   cmd_ready,
    output logic   snd_intr
);

    ser_sel_t ser_sel;
    logic     sel_attn;
    logic     sel_gps;
    logic     sel_dna;

    //////////////////////////////
    // control register
    //////////////////////////////

    // low 14 bits of tos, loaded on set_ctrl
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            ctrl <= '0;
        end
        else if (bus.wr_reg && bus.op[op_set_ctrl])
        begin
            ctrl <= bus.tos[13:0];
        end
    end

    //////////////////////////////
    // serial steering
    //////////////////////////////

    // select lives in the two lsbs
    assign ser_sel  = ser_sel_t'(ctrl[1:0]);

    // one target at most, code 0 parks all
    assign sel_attn = (ser_sel == ser_attn);
    assign sel_gps  = (ser_sel == ser_gps);
    assign sel_dna  = (ser_sel == ser_dna);

    // attenuator: latch enable, clock, data
    assign da_dale   = sel_attn & ctrl[ctrl_ser_le_csn];
    assign da_daclk  = sel_attn & ctrl[ctrl_ser_clk];
    assign da_dadat  = sel_attn & ctrl[ctrl_ser_data];

    // gps front end: chip select, clock, data
    assign gps_gscs  = sel_gps & ctrl[ctrl_ser_le_csn];
    assign gps_gsclk = sel_gps & ctrl[ctrl_ser_clk];
    assign gps_gsdat = sel_gps & ctrl[ctrl_ser_data];

    // device id: read, clock, shift
    assign dna_read  = sel_dna & ctrl[ctrl_ser_le_csn];
    assign dna_clk   = sel_dna & ctrl[ctrl_ser_clk];
    assign dna_shift = sel_dna & ctrl[ctrl_ser_data];

    //////////////////////////////
    // direct pins
    //////////////////////////////

    // active-low enables, high out of reset
    assign adc_clken = ~ctrl[ctrl_osc_dis];
    assign adc_stenl = ~ctrl[ctrl_sten];

    // eeprom write protect
    assign ewp       = ctrl[ctrl_eeprom_wp];
    // handshake lines to the host
    assign cmd_ready = ctrl[ctrl_cmd_ready];
    assign snd_intr  = ctrl[ctrl_snd_intr];

endmodule

// File: design/cycle_counters.sv
`timescale 1ns/10ps

module cycle_counters
    import kiwi_io_pkg::*;
(
    cpu_bus_if.snk bus,
    input  logic   cpu_clk,
    input  logic   rx_orst,
    output ctr_t   ctr0,
    output ctr_t   ctr1
);

    logic clr_evt;
    logic ena_evt;
    logic dis_evt;
    logic ctr_ena;

    // event decode, one cycle strobes
    assign clr_evt = bus.wr_evt & bus.op[op_ctr_clr];
    assign ena_evt = bus.wr_evt & bus.op[op_ctr_ena];
    assign dis_evt = bus.wr_evt & bus.op[op_ctr_dis];

    //////////////////////////////
    // enable flag
    //////////////////////////////

    // new value counts from the next edge
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            ctr_ena <= 1'b0;
        end
        else if (ena_evt)
        begin
            ctr_ena <= 1'b1;
        end
        else if (dis_evt)
        begin
            ctr_ena <= 1'b0;
        end
    end

    //////////////////////////////
    // accumulators
    //////////////////////////////

    // ctr0 = total cycles, ctr1 = enabled cycles
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst || clr_evt)
        begin
            ctr0 <= '0;
            ctr1 <= '0;
        end
        else
        begin
            ctr0 <= ctr0 + ctr_t'(1);
            // busy count only
            if (ctr_ena)
            begin
                ctr1 <= ctr1 + ctr_t'(1);
            end
        end
    end

endmodule

// File: design/event_latches.sv
`timescale 1ns/10ps

module event_latches
    import kiwi_io_pkg::*;
(
    cpu_bus_if.snk bus,
    input  logic   cpu_clk,
    input  logic   rx_orst,
    input  logic   host_srq,
    input  logic   rx_ovfl,
    output logic   overflow,
    output logic   ser
);

    logic srq_poll;
    logic srq_noted;
    logic srq_out;

    //////////////////////////////
    // receiver overflow
    //////////////////////////////

    // sticky until reset
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            overflow <= 1'b0;
        end
        else
        begin
            overflow <= overflow | rx_ovfl;
        end
    end

    //////////////////////////////
    // service request capture
    //////////////////////////////

    // cpu polls with a get_srq read
    assign srq_poll = bus.rd_reg & bus.op[op_get_srq];

    // a request landing on the poll edge rolls into the next poll
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            srq_noted <= 1'b0;
            srq_out   <= 1'b0;
        end
        else if (srq_poll)
        begin
            srq_noted <= host_srq;
            srq_out   <= srq_noted;
        end
        else
        begin
            srq_noted <= srq_noted | host_srq;
        end
    end

    // poll result on the serial input bit
    assign ser = srq_out;

endmodule

// File: design/kiwi_io_pkg.sv
package kiwi_io_pkg;

    //////////////////////////////
    // vector types
    //////////////////////////////

    // one-hot opcode field from the eCPU
    typedef logic [15:0] op_t;
    // top-of-stack word
    typedef logic [31:0] word_t;
    // parallel read word back to the cpu
    typedef logic [15:0] par_t;
    // global control register
    typedef logic [13:0] ctrl_t;
    // cycle counter value
    typedef logic [31:0] ctr_t;
    // serial target select, ctrl[1:0]
    typedef logic [1:0]  ser_sel_t;

    //////////////////////////////
    // opcode bit positions
    //////////////////////////////

    localparam logic [3:0] op_set_ctrl   = 4'd0;
    localparam logic [3:0] op_get_status = 4'd1;
    localparam logic [3:0] op_get_srq    = 4'd2;
    // counter byte reads, byte 0 to 3
    localparam logic [3:0] op_get_ctr0   = 4'd3;
    localparam logic [3:0] op_get_ctr1   = 4'd4;
    localparam logic [3:0] op_get_ctr2   = 4'd5;
    localparam logic [3:0] op_get_ctr3   = 4'd6;
    // counter events
    localparam logic [3:0] op_ctr_clr    = 4'd7;
    localparam logic [3:0] op_ctr_ena    = 4'd8;
    localparam logic [3:0] op_ctr_dis    = 4'd9;

    //////////////////////////////
    // control bit positions
    //////////////////////////////

    // bits 1..0 hold the serial select
    localparam logic [3:0] ctrl_ser_le_csn = 4'd2;
    localparam logic [3:0] ctrl_ser_clk    = 4'd3;
    localparam logic [3:0] ctrl_ser_data   = 4'd4;
    localparam logic [3:0] ctrl_osc_dis    = 4'd5;
    localparam logic [3:0] ctrl_sten       = 4'd6;
    localparam logic [3:0] ctrl_eeprom_wp  = 4'd7;
    localparam logic [3:0] ctrl_cmd_ready  = 4'd8;
    localparam logic [3:0] ctrl_snd_intr   = 4'd9;

    // serial targets, code 0 leaves all lines parked low
    localparam ser_sel_t ser_attn = 2'd1;
    localparam ser_sel_t ser_gps  = 2'd2;
    localparam ser_sel_t ser_dna  = 2'd3;

    // status word nibbles
    localparam logic [3:0] fpga_ver = 4'd1;
    localparam logic [3:0] fpga_id  = 4'd4;

endpackage

// File: design/kiwi_io_top.sv
`timescale 1ns/10ps

module kiwi_io_top
    import kiwi_io_pkg::*;
(
    input  logic  cpu_clk,
    input  logic  rx_orst,
    // cpu strobes and data
    input  logic  rd_reg,
    input  logic  wr_reg,
    input  logic  wr_evt,
    input  op_t   op,
    input  word_t tos,
    // async-ish event inputs
    input  logic  host_srq,
    input  logic  rx_ovfl,
    input  logic  dna_data,
    // host read data, mux default
    input  par_t  host_dout,
    output par_t  par,
    output logic  ser,
    // pins
    output logic  adc_clken,
    output logic  adc_stenl,
    output logic  da_dale,
    output logic  da_daclk,
    output logic  da_dadat,
    output logic  gps_gscs,
    output logic  gps_gsclk,
    output logic  gps_gsdat,
    output logic  dna_read,
    output logic  dna_clk,
    output logic  dna_shift,
    output logic  ewp,
    output logic  cmd_ready,
    output logic  snd_intr
);

    ctrl_t ctrl;
    ctr_t  ctr0;
    ctr_t  ctr1;
    logic  overflow;

    //////////////////////////////
    // cpu bus
    //////////////////////////////

    cpu_bus_if bus ();

    // ports stand in for the cpu core
    assign bus.op     = op;
    assign bus.tos    = tos;
    assign bus.rd_reg = rd_reg;
    assign bus.wr_reg = wr_reg;
    assign bus.wr_evt = wr_evt;

    //////////////////////////////
    // io blocks
    //////////////////////////////

    // control register and pin steering
    ctrl_regs u_ctrl_regs
    (
        .bus       (bus),
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .ctrl      (ctrl),
        .adc_clken (adc_clken),
        .adc_stenl (adc_stenl),
        .da_dale   (da_dale),
        .da_daclk  (da_daclk),
        .da_dadat  (da_dadat),
        .gps_gscs  (gps_gscs),
        .gps_gsclk (gps_gsclk),
        .gps_gsdat (gps_gsdat),
        .dna_read  (dna_read),
        .dna_clk   (dna_clk),
        .dna_shift (dna_shift),
        .ewp       (ewp),
        .cmd_ready (cmd_ready),
        .snd_intr  (snd_intr)
    );

    // total and busy cycle counts
    cycle_counters u_cycle_counters
    (
        .bus     (bus),
        .cpu_clk (cpu_clk),
        .rx_orst (rx_orst),
        .ctr0    (ctr0),
        .ctr1    (ctr1)
    );

    // overflow flag, srq capture
    event_latches u_event_latches
    (
        .bus      (bus),
        .cpu_clk  (cpu_clk),
        .rx_orst  (rx_orst),
        .host_srq (host_srq),
        .rx_ovfl  (rx_ovfl),
        .overflow (overflow),
        .ser      (ser)
    );

    // parallel input to the cpu
    par_mux u_par_mux
    (
        .bus       (bus),
        .ctr0      (ctr0),
        .ctr1      (ctr1),
        .overflow  (overflow),
        .dna_data  (dna_data),
        .host_dout (host_dout),
        .par       (par)
    );

endmodule

// File: design/par_mux.sv
`timescale 1ns/10ps

module par_mux
    import kiwi_io_pkg::*;
(
    cpu_bus_if.snk bus,
    input  ctr_t   ctr0,
    input  ctr_t   ctr1,
    input  logic   overflow,
    input  logic   dna_data,
    input  par_t   host_dout,
    output par_t   par
);

    par_t       status;
    logic [3:0] stat_user;

    //////////////////////////////
    // status word
    //////////////////////////////

    // user flags: three spare, then dna bit
    assign stat_user = {3'b000, dna_data};

    // ovfl | 000 | ver | user | id
    assign status = {overflow, 3'b000, fpga_ver, stat_user, fpga_id};

    //////////////////////////////
    // read mux
    //////////////////////////////

    // counter bytes first, then status, else host data
    always_comb
    begin
        if (bus.rd_reg && bus.op[op_get_ctr0])
        begin
            par = {ctr1[7:0], ctr0[7:0]};
        end
        else if (bus.rd_reg && bus.op[op_get_ctr1])
        begin
            par = {ctr1[15:8], ctr0[15:8]};
        end
        else if (bus.rd_reg && bus.op[op_get_ctr2])
        begin
            par = {ctr1[23:16], ctr0[23:16]};
        end
        else if (bus.rd_reg && bus.op[op_get_ctr3])
        begin
            par = {ctr1[31:24], ctr0[31:24]};
        end
        else if (bus.rd_reg && bus.op[op_get_status])
        begin
            par = status;
        end
        else
        begin
            // default path, host spi read data
            par = host_dout;
        end
    end

endmodule

// File: verif/kiwi_io_sva.sv
`timescale 1ns/10ps

module kiwi_io_sva
    import kiwi_io_pkg::*;
(
    input logic       cpu_clk,
    input logic       rx_orst,
    input logic       wr_reg,
    input op_t        op,
    input word_t      tos,
    input logic       adc_stenl,
    input logic       ewp,
    // le, clk, data per target
    input logic [2:0] attn_lines,
    input logic [2:0] gps_lines,
    input logic [2:0] dna_lines
);

    int   fail_count = 0;
    logic sten_q;

    //////////////////////////////
    // bus side shadow
    //////////////////////////////

    // self-test bit as last written on the bus
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            sten_q <= 1'b0;
        end
        else if (wr_reg && op[op_set_ctrl])
        begin
            sten_q <= tos[ctrl_sten];
        end
    end

    //////////////////////////////
    // steering and pin checks
    //////////////////////////////

    // never two targets at once
    assert property (@(posedge cpu_clk) disable iff (rx_orst)
        $onehot0({|attn_lines, |gps_lines, |dna_lines}))
    else
    begin
        $error("more than one serial target active");
        fail_count = fail_count + 1;
    end

    // active-low self test
    assert property (@(posedge cpu_clk) disable iff (rx_orst) adc_stenl == ~sten_q)
    else
    begin
        $error("adc_stenl does not follow the self-test bit");
        fail_count = fail_count + 1;
    end

    // write protect lands one cycle after set_ctrl
    assert property (@(posedge cpu_clk) disable iff (rx_orst)
        (wr_reg && op[op_set_ctrl]) |=> (ewp == $past(tos[ctrl_eeprom_wp])))
    else
    begin
        $error("ewp does not match the written bit");
        fail_count = fail_count + 1;
    end

endmodule

bind ctrl_regs kiwi_io_sva u_sva
(
    .cpu_clk    (cpu_clk),
    .rx_orst    (rx_orst),
    .wr_reg     (bus.wr_reg),
    .op         (bus.op),
    .tos        (bus.tos),
    .adc_stenl  (adc_stenl),
    .ewp        (ewp),
    .attn_lines ({da_dale, da_daclk, da_dadat}),
    .gps_lines  ({gps_gscs, gps_gsclk, gps_gsdat}),
    .dna_lines  ({dna_read, dna_clk, dna_shift})
);

// File: verif/kiwi_io_tb.sv
`timescale 1ns/10ps

module kiwi_io_tb
    import kiwi_io_pkg::*;
();

    localparam int clk_period = 4;
    // expected par source per row
    localparam int pk_lit  = 0;
    localparam int pk_host = 1;
    localparam int pk_ctr  = 2;
    // pin vector: clken stenl | da le clk dat | gps cs clk dat | dna rd clk sh | ewp cmd snd
    localparam logic [13:0] pins_rst  = 14'b11_000_000_000_000;
    localparam logic [13:0] pins_attn = 14'b11_101_000_000_101;
    localparam logic [13:0] pins_gps  = 14'b01_000_011_000_010;
    localparam logic [13:0] pins_dna  = 14'b10_000_000_110_111;

    logic  cpu_clk, rx_orst, rd_reg, wr_reg, wr_evt;
    logic  host_srq, rx_ovfl, dna_data, ser;
    op_t   op;
    word_t tos;
    par_t  host_dout, par;
    logic  adc_clken, adc_stenl, ewp, cmd_ready, snd_intr;
    logic  da_dale, da_daclk, da_dadat, gps_gscs, gps_gsclk, gps_gsdat;
    logic  dna_read, dna_clk, dna_shift;
    logic [13:0] pins;

    // stimulus table, one entry per cycle
    string       row_name[$];
    op_t         row_op[$];
    word_t       row_tos[$];
    logic [5:0]  row_ctl[$];
    int          row_kind[$];
    par_t        row_par[$];
    logic        row_ser[$];
    logic [13:0] row_pins[$];
    int          n_rows = 0;

    // counter model and host data source
    ctr_t        m_ctr0, m_ctr1;
    logic        m_ena;
    logic [31:0] lfsr;
    par_t        cur_host;

    kiwi_io_top UUT (.*);

    assign pins = {adc_clken, adc_stenl, da_dale, da_daclk, da_dadat,
                   gps_gscs, gps_gsclk, gps_gsdat, dna_read, dna_clk, dna_shift,
                   ewp, cmd_ready, snd_intr};

    always #(clk_period / 2) cpu_clk = ~cpu_clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic op_t op_of(input logic [3:0] idx);
        op_t v;
        v = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per host_dout bit
    task automatic draw_host(output par_t v);
        v = '0;
        for (int j = 0; j < 16; j++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    function automatic int ctr_byte(input op_t o);
        return o[op_get_ctr0] ? 0 : o[op_get_ctr1] ? 1 : o[op_get_ctr2] ? 2 : 3;
    endfunction

    // ctl = {rd, wr, evt, srq, ovfl, dna}
    task automatic add_row(input string n, input op_t o, input word_t t, input logic [5:0] c,
                           input int k, input par_t p, input logic s, input logic [13:0] pn);
        row_name.push_back(n);
        row_op.push_back(o);
        row_tos.push_back(t);
        row_ctl.push_back(c);
        row_kind.push_back(k);
        row_par.push_back(p);
        row_ser.push_back(s);
        row_pins.push_back(pn);
    endtask

    // counters as seen after this edge
    task model_step();
        if (rx_orst || (wr_evt && op[op_ctr_clr]))
        begin
            m_ctr0 = '0;
            m_ctr1 = '0;
        end
        else
        begin
            m_ctr0 = m_ctr0 + 1;
            if (m_ena)
            begin
                m_ctr1 = m_ctr1 + 1;
            end
        end
        // enable takes effect one edge later
        if (rx_orst)
        begin
            m_ena = 1'b0;
        end
        else if (wr_evt && op[op_ctr_ena])
        begin
            m_ena = 1'b1;
        end
        else if (wr_evt && op[op_ctr_dis])
        begin
            m_ena = 1'b0;
        end
    endtask

    task check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("mismatch %s: expected %0h actual %0h", name, exp, act);
            $display("sim failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    task build_table();
        // pins follow a write one cycle late
        add_row("reset_idle", '0, '0, 6'b000_000, pk_host, '0, 0, pins_rst);
        add_row("wr_attn", op_of(op_set_ctrl), 32'h295, 6'b010_000, pk_host, '0, 0, pins_rst);
        add_row("attn_pins", '0, '0, 6'b000_000, pk_host, '0, 0, pins_attn);
        add_row("wr_gps", op_of(op_set_ctrl), 32'h13a, 6'b010_000, pk_host, '0, 0, pins_attn);
        add_row("gps_pins", '0, '0, 6'b000_000, pk_host, '0, 0, pins_gps);
        add_row("wr_dna", op_of(op_set_ctrl), 32'h3cf, 6'b010_000, pk_host, '0, 0, pins_gps);
        add_row("dna_pins", '0, '0, 6'b000_000, pk_host, '0, 0, pins_dna);
        // select 0 with serial bits set, upper tos ignored
        add_row("wr_park", op_of(op_set_ctrl), 32'hffff_c01c, 6'b010_000, pk_host, '0, 0, pins_dna);
        add_row("park_pins", '0, '0, 6'b000_000, pk_host, '0, 0, pins_rst);
        // status reads beat host data
        add_row("stat_dna1", op_of(op_get_status), '0, 6'b100_001, pk_lit, 16'h0114, 0, pins_rst);
        add_row("stat_dna0", op_of(op_get_status), '0, 6'b100_000, pk_lit, 16'h0104, 0, pins_rst);
        add_row("rd_no_op", '0, '0, 6'b100_000, pk_host, '0, 0, pins_rst);
        add_row("wr_status", op_of(op_get_status), 32'h3fff, 6'b010_000, pk_host, '0, 0, pins_rst);
        add_row("ovfl_pulse", '0, '0, 6'b000_010, pk_host, '0, 0, pins_rst);
        add_row("stat_ovfl", op_of(op_get_status), '0, 6'b100_001, pk_lit, 16'h8114, 0, pins_rst);
        add_row("stat_sticky", op_of(op_get_status), '0, 6'b100_000, pk_lit, 16'h8104, 0, pins_rst);
        // counters against the model
        add_row("ctr_clr", op_of(op_ctr_clr), '0, 6'b001_000, pk_host, '0, 0, pins_rst);
        add_row("ctr_rd_a", op_of(op_get_ctr0), '0, 6'b100_000, pk_ctr, '0, 0, pins_rst);
        add_row("ctr_ena", op_of(op_ctr_ena), '0, 6'b001_000, pk_host, '0, 0, pins_rst);
        add_row("ctr_rd_b", op_of(op_get_ctr0), '0, 6'b100_000, pk_ctr, '0, 0, pins_rst);
        add_row("ctr_rd_c", op_of(op_get_ctr0), '0, 6'b100_000, pk_ctr, '0, 0, pins_rst);
        add_row("ctr_dis", op_of(op_ctr_dis), '0, 6'b001_000, pk_host, '0, 0, pins_rst);
        add_row("ctr_rd_d", op_of(op_get_ctr0), '0, 6'b100_000, pk_ctr, '0, 0, pins_rst);
        add_row("ctr_rd_e", op_of(op_get_ctr0), '0, 6'b100_000, pk_ctr, '0, 0, pins_rst);
        add_row("ctr_ena_run", op_of(op_ctr_ena), '0, 6'b001_000, pk_host, '0, 0, pins_rst);
        // long run so byte 1 moves
        for (int i = 0; i < 300; i++)
        begin
            add_row("ctr_run", '0, '0, 6'b000_000, pk_host, '0, 0, pins_rst);
        end
        add_row("ctr_dis_run", op_of(op_ctr_dis), '0, 6'b001_000, pk_host, '0, 0, pins_rst);
        add_row("ctr_byte0", op_of(op_get_ctr0), '0, 6'b100_000, pk_ctr, '0, 0, pins_rst);
        add_row("ctr_byte1", op_of(op_get_ctr1), '0, 6'b100_000, pk_ctr, '0, 0, pins_rst);
        add_row("ctr_byte2", op_of(op_get_ctr2), '0, 6'b100_000, pk_ctr, '0, 0, pins_rst);
        add_row("ctr_byte3", op_of(op_get_ctr3), '0, 6'b100_000, pk_ctr, '0, 0, pins_rst);
        add_row("ctr_over_stat", op_of(op_get_ctr1) | op_of(op_get_status), '0, 6'b100_001,
                pk_ctr, '0, 0, pins_rst);
        // srq polls, result on ser one cycle after the poll
        add_row("srq_poll_empty", op_of(op_get_srq), '0, 6'b100_000, pk_host, '0, 0, pins_rst);
        add_row("srq_after_empty", '0, '0, 6'b000_000, pk_host, '0, 0, pins_rst);
        add_row("srq_pulse", '0, '0, 6'b000_100, pk_host, '0, 0, pins_rst);
        add_row("srq_wait", '0, '0, 6'b000_000, pk_host, '0, 0, pins_rst);
        add_row("srq_poll_req", op_of(op_get_srq), '0, 6'b100_000, pk_host, '0, 0, pins_rst);
        add_row("srq_after_req", '0, '0, 6'b000_000, pk_host, '0, 1, pins_rst);
        add_row("srq_poll_again", op_of(op_get_srq), '0, 6'b100_000, pk_host, '0, 1, pins_rst);
        add_row("srq_after_again", '0, '0, 6'b000_000, pk_host, '0, 0, pins_rst);
        // request on the poll edge rolls into the next poll
        add_row("srq_poll_edge", op_of(op_get_srq), '0, 6'b100_100, pk_host, '0, 0, pins_rst);
        add_row("srq_after_edge", '0, '0, 6'b000_000, pk_host, '0, 0, pins_rst);
        add_row("srq_poll_late", op_of(op_get_srq), '0, 6'b100_000, pk_host, '0, 0, pins_rst);
        add_row("srq_after_late", '0, '0, 6'b000_000, pk_host, '0, 1, pins_rst);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        par_t       exp_par;
        int         b;
        logic [5:0] c;
        cpu_clk   = 1'b0;
        rx_orst   = 1'b1;
        rd_reg    = 1'b0;
        wr_reg    = 1'b0;
        wr_evt    = 1'b0;
        host_srq  = 1'b0;
        rx_ovfl   = 1'b0;
        dna_data  = 1'b0;
        op        = '0;
        tos       = '0;
        host_dout = '0;
        lfsr      = 32'h6f3b;
        m_ctr0    = '0;
        m_ctr1    = '0;
        m_ena     = 1'b0;
        build_table();
        n_rows = row_name.size();
        // 4 reset cycles
        repeat (4)
        begin
            @(posedge cpu_clk);
            model_step();
        end
        rx_orst <= 1'b0;
        for (int i = 0; i < n_rows; i++)
        begin
            @(posedge cpu_clk);
            model_step();
            draw_host(cur_host);
            c = row_ctl[i];
            op        <= row_op[i];
            tos       <= row_tos[i];
            rd_reg    <= c[5];
            wr_reg    <= c[4];
            wr_evt    <= c[3];
            host_srq  <= c[2];
            rx_ovfl   <= c[1];
            dna_data  <= c[0];
            host_dout <= cur_host;
            // mid cycle, everything settled
            @(negedge cpu_clk);
            case (row_kind[i])
                pk_lit:
                begin
                    exp_par = row_par[i];
                end
                pk_ctr:
                begin
                    b = ctr_byte(row_op[i]);
                    exp_par = {m_ctr1[8*b +: 8], m_ctr0[8*b +: 8]};
                end
                default:
                begin
                    exp_par = cur_host;
                end
            endcase
            check_value($sformatf("%s par", row_name[i]), exp_par, par);
            check_value($sformatf("%s ser", row_name[i]), row_ser[i], ser);
            check_value($sformatf("%s pins", row_name[i]), row_pins[i], pins);
        end
        // let the last assertions sample
        repeat (2) @(posedge cpu_clk);
        if (UUT.u_ctrl_regs.u_sva.fail_count != 0)
        begin
            $display("bound assertions failed %0d times", UUT.u_ctrl_regs.u_sva.fail_count);
            $display("sim failed");
            $fatal(1, "assertion failures");
        end
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

    // watchdog, table length plus reset plus margin
    initial
    begin
        wait (n_rows > 0);
        #((n_rows + 4 + 20) * clk_period);
        $display("timeout: the table did not finish in time");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule
